/* compile.f */
src/uart_pkg.sv
src/uart_tx_ctrl_if.sv
src/baud_timer.sv
src/uart_tx_fsm.sv
src/tx_shifter.sv
src/uart_tx_top.sv
sim/tb_clock_gen.sv
sim/uart_tx_properties.sv
sim/uart_tx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the uart transmitter testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
status=0
verilator --binary --timing --assert --timescale 1ns/100ps -f compile.f \
    --top-module uart_tx_tb \
    && ./obj_dir/Vuart_tx_tb > sim.log 2>&1 \
    || status=1
[ -f sim.log ] && cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && status=1
exit $status

/* sim/tb_clock_gen.sv */
// testbench clock and reset source
// free running clock, reset held low for a set number of cycles
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic s_axis,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        s_axis = 1'b0;
        forever begin
            #(HALF_PERIOD) s_axis = ~s_axis;
        end
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge s_axis);
        @(negedge s_axis);
        rst_n_o = 1'b1;  // released on a falling edge like every other input
    end

endmodule

`default_nettype wire

/* sim/uart_tx_properties.sv */
// concurrent assertions on the transmitter ports
// tready returns only after WAIT, line idles high, tready is up after reset
`default_nettype none

module uart_tx_properties
    import uart_pkg::*;
(
    input logic        s_axis,
    input logic        rst_n_i,
    input uart_state_e state_i,
    input logic        s_axis_tready_i,
    input logic        uart_tx_i
);
    timeunit 1ns;
    timeprecision 100ps;

    tready_low_when_busy: assert property (@(posedge s_axis) disable iff (!rst_n_i)
        $rose(s_axis_tready_i) |-> ($past(state_i) == WAIT))
        else $error("tready rose before the frame had ended");

    line_high_when_idle: assert property (@(posedge s_axis) disable iff (!rst_n_i)
        (state_i == IDLE) |-> uart_tx_i)
        else $error("serial line is low in IDLE");

    tready_after_reset: assert property (@(posedge s_axis)
        $rose(rst_n_i) |-> s_axis_tready_i)
        else $error("tready is low right after reset");

endmodule

bind uart_tx_top uart_tx_properties props0 (
    .s_axis          (s_axis),
    .rst_n_i         (rst_n_i),
    .state_i         (u_fsm.state_q),
    .s_axis_tready_i (s_axis_tready_o),
    .uart_tx_i       (uart_tx_o)
);

`default_nettype wire

/* sim/uart_tx_tb.sv */
// directed testbench for the axi-stream uart transmitter
// serial line monitor, compare tasks, lfsr stimulus,
// watchdog and closing verdict
`default_nettype none

module uart_tx_tb
    import uart_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_WIDTH    = DEF_DATA_WIDTH;
    localparam int DIVIDER_WIDTH = DEF_DIVIDER_WIDTH;
    localparam int N_RANDOM      = 6;  // frames in each random test

    function automatic int frame_cycles(input int div, input int parity_bits);
        return (DATA_WIDTH + 2 + parity_bits) * div + 4;  // frame plus handshake gap
    endfunction

    // reset, three random tests at divider 4, four frames at 7, two back-pressure frames
    localparam int WATCHDOG_CYCLES = 20 + N_RANDOM * frame_cycles(4, 0) +
        2 * N_RANDOM * frame_cycles(4, 1) + 4 * frame_cycles(7, 0) +
        2 * frame_cycles(4, 0) + 100;

    logic                     s_axis;
    logic                     rst_n;
    logic [DATA_WIDTH-1:0]    s_axis_tdata;
    logic                     s_axis_tvalid;
    logic                     s_axis_tready;
    logic [DIVIDER_WIDTH-1:0] clk_divider;
    logic                     odd;
    logic                     even;
    logic                     uart_tx;
    logic [31:0]              lfsr_state;
    int                       checks;
    int                       mismatches;
    int                       failures;
    time                      accept_time;  // clock edge of the latest byte transfer

    tb_clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(4)) clk_gen0 (
        .s_axis  (s_axis),
        .rst_n_o (rst_n)
    );

    uart_tx_top #(.DATA_WIDTH(DATA_WIDTH), .DIVIDER_WIDTH(DIVIDER_WIDTH)) dut0 (
        .s_axis          (s_axis),
        .rst_n_i         (rst_n),
        .s_axis_tdata_i  (s_axis_tdata),
        .s_axis_tvalid_i (s_axis_tvalid),
        .s_axis_tready_o (s_axis_tready),
        .clk_divider_i   (clk_divider),
        .odd_i           (odd),
        .even_i          (even),
        .uart_tx_o       (uart_tx)
    );

    // fibonacci lfsr with taps 32, 22, 2 and 1
    function automatic logic next_random_bit();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] random_word();
        logic [DATA_WIDTH-1:0] w;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            w[i] = next_random_bit();
        end
        return w;
    endfunction

    task automatic compare_word(input string name, input logic [DATA_WIDTH-1:0] exp,
                                input logic [DATA_WIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic wait_idle(input string name);
        int waited;
        waited = 0;
        while (!s_axis_tready && waited < frame_cycles(int'(clk_divider), 1)) begin
            @(negedge s_axis);
            waited++;
        end
        if (!s_axis_tready) begin
            failures++;
            $display("%s: transmitter did not return to idle in time", name);
        end
    endtask

    // present a byte and hold it until the transfer edge has passed
    task automatic offer_byte(input string name, input logic [DATA_WIDTH-1:0] word);
        s_axis_tdata  = word;
        s_axis_tvalid = 1'b1;
        wait_idle(name);
        @(posedge s_axis);
        accept_time = $time;
        @(negedge s_axis);
    endtask

    // samples every bit on each falling clock edge, keeps the mid-bit value
    task automatic receive_frame(input string name, input int div, input logic with_parity,
                                 output logic [DATA_WIDTH-1:0] word, output logic par,
                                 output logic stop);
        int   nbits;
        logic level0;
        logic mid;
        logic stable;
        logic bits [0:MAX_DATA_WIDTH+2];
        nbits = DATA_WIDTH + 2 + (with_parity ? 1 : 0);
        par   = 1'b0;
        @(negedge uart_tx);
        for (int i = 0; i < nbits; i++) begin
            stable = 1'b1;
            for (int j = 0; j < div; j++) begin
                @(negedge s_axis);
                if (j == 0) level0 = uart_tx;
                else if (uart_tx !== level0) stable = 1'b0;
                if (j == div / 2) mid = uart_tx;
            end
            if (!stable) begin
                failures++;
                $display("%s: line changed inside bit %0d of the frame", name, i);
            end
            bits[i] = mid;
        end
        compare_bit({name, " start bit"}, 1'b0, bits[0]);
        for (int i = 0; i < DATA_WIDTH; i++) begin
            word[i] = bits[i + 1];
        end
        if (with_parity) par = bits[DATA_WIDTH + 1];
        stop = bits[nbits - 1];
    endtask

    task automatic configure(input int div, input logic odd_en, input logic even_en);
        wait_idle("configure");
        clk_divider = DIVIDER_WIDTH'(div);
        odd         = odd_en;
        even        = even_en;
    endtask

    task automatic send_and_check(input string name, input logic [DATA_WIDTH-1:0] word,
                                  input logic with_parity, input logic exp_par);
        logic [DATA_WIDTH-1:0] got;
        logic                  got_par;
        logic                  got_stop;
        fork
            begin
                offer_byte(name, word);
                s_axis_tvalid = 1'b0;
            end
            receive_frame(name, int'(clk_divider), with_parity, got, got_par, got_stop);
        join
        compare_word(name, word, got);
        if (with_parity) compare_bit({name, " parity"}, exp_par, got_par);
        compare_bit({name, " stop bit"}, 1'b1, got_stop);
    endtask

    task automatic test_reset();
        compare_bit("reset line", 1'b1, uart_tx);
        compare_bit("reset tready", 1'b1, s_axis_tready);
    endtask

    task automatic test_no_parity();
        configure(4, 1'b0, 1'b0);
        for (int n = 0; n < N_RANDOM; n++) begin
            send_and_check("no parity", random_word(), 1'b0, 1'b0);
        end
    endtask

    task automatic test_even_parity();
        logic [DATA_WIDTH-1:0] w;
        configure(4, 1'b0, 1'b1);
        for (int n = 0; n < N_RANDOM; n++) begin
            w = random_word();
            send_and_check("even parity", w, 1'b1, ^w);  // even count of ones overall
        end
    endtask

    task automatic test_odd_wins();
        logic [DATA_WIDTH-1:0] w;
        configure(4, 1'b1, 1'b1);
        for (int n = 0; n < N_RANDOM; n++) begin
            w = random_word();
            send_and_check("odd parity", w, 1'b1, ~^w);
        end
    endtask

    task automatic test_divider();
        logic [DATA_WIDTH-1:0] alt;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            alt[i] = i[0];  // toggles on every data bit
        end
        configure(7, 1'b0, 1'b0);
        send_and_check("divider 7", alt, 1'b0, 1'b0);
        send_and_check("divider 7", ~alt, 1'b0, 1'b0);
        send_and_check("divider 7", random_word(), 1'b0, 1'b0);
        send_and_check("divider 7", random_word(), 1'b0, 1'b0);
    endtask

    task automatic test_back_pressure();
        logic [DATA_WIDTH-1:0] first;
        logic [DATA_WIDTH-1:0] second;
        logic [DATA_WIDTH-1:0] got_first;
        logic [DATA_WIDTH-1:0] got_second;
        logic                  par;
        logic                  stop_first;
        logic                  stop_second;
        time                   first_end;
        time                   second_accept;
        first  = random_word();
        second = random_word();
        configure(4, 1'b0, 1'b0);
        fork
            begin
                offer_byte("back-pressure", first);
                compare_bit("back-pressure tready", 1'b0, s_axis_tready);
                offer_byte("back-pressure", second);  // tvalid stays high in between
                second_accept = accept_time;
                s_axis_tvalid = 1'b0;
            end
            begin
                receive_frame("back-pressure", 4, 1'b0, got_first, par, stop_first);
                first_end = $time;
                receive_frame("back-pressure", 4, 1'b0, got_second, par, stop_second);
            end
        join
        compare_word("back-pressure first byte", first, got_first);
        compare_word("back-pressure second byte", second, got_second);
        compare_bit("back-pressure first stop", 1'b1, stop_first);
        compare_bit("back-pressure second stop", 1'b1, stop_second);
        if (second_accept <= first_end) begin
            failures++;
            $display("back-pressure: second byte was accepted before the first frame ended");
        end
    endtask

    initial begin : main
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        clk_divider   = DIVIDER_WIDTH'(4);
        odd           = 1'b0;
        even          = 1'b0;
        lfsr_state    = 32'h121d_6d31;
        checks        = 0;
        mismatches    = 0;
        failures      = 0;
        @(posedge rst_n);
        @(negedge s_axis);
        test_reset();
        test_no_parity();
        test_even_parity();
        test_odd_wins();
        test_divider();
        test_back_pressure();
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge s_axis);
        $display("watchdog: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* src/baud_timer.sv */
// bit period timer
// pulses baud_done_o once every clk_divider_i cycles while enabled
`default_nettype none

module baud_timer
    import uart_pkg::*;
#(
    parameter int DIVIDER_WIDTH = DEF_DIVIDER_WIDTH
) (
    input  logic                     s_axis,
    input  logic                     rst_n_i,
    input  logic                     baud_en_i,
    input  logic [DIVIDER_WIDTH-1:0] clk_divider_i,
    output logic                     baud_done_o
);

    localparam logic [DIVIDER_WIDTH-1:0] ONE = 1;

    logic [DIVIDER_WIDTH-1:0] cnt_q;
    logic [DIVIDER_WIDTH-1:0] cnt_last;
    logic                     wrap;

    assign cnt_last    = clk_divider_i - ONE;
    assign wrap        = (cnt_q == cnt_last);
    assign baud_done_o = baud_en_i & wrap;

    always_ff @(posedge s_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (!baud_en_i || wrap) begin
            cnt_q <= '0;  // a fresh enable always starts a full period
        end else begin
            cnt_q <= cnt_q + ONE;
        end
    end

endmodule

`default_nettype wire

/* src/tx_shifter.sv */
// transmit data path
// holds the data word, shifts it out lsb first, counts the bits,
// keeps the parity bit and registers the serial line
`default_nettype none

module tx_shifter
    import uart_pkg::*;
#(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH
) (
    input  logic                  s_axis,
    input  logic                  rst_n_i,
    input  logic [DATA_WIDTH-1:0] s_axis_tdata_i,
    input  logic                  odd_i,
    uart_tx_ctrl_if.shifter       ctrl,
    output logic                  uart_tx_o
);

    localparam int               CNT_W    = $clog2(DATA_WIDTH);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_WIDTH - 1);
    localparam logic [CNT_W-1:0] CNT_ONE  = 1;

    logic [DATA_WIDTH-1:0] data_q;
    logic                  parity_q;
    logic [CNT_W-1:0]      bit_cnt_q;
    logic                  line_d;

    assign ctrl.bit_last = (bit_cnt_q == LAST_BIT);

    always_ff @(posedge s_axis) begin
        if (ctrl.load) begin
            data_q   <= s_axis_tdata_i;
            parity_q <= parity_bit(MAX_DATA_WIDTH'(s_axis_tdata_i), odd_i);
        end else if (ctrl.shift) begin
            data_q <= data_q >> 1;  // bit 0 is always the one on the line
        end
    end

    always_ff @(posedge s_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_cnt_q <= '0;
        end else if (ctrl.load) begin
            bit_cnt_q <= '0;
        end else if (ctrl.shift) begin
            bit_cnt_q <= bit_cnt_q + CNT_ONE;
        end
    end

    always_comb begin
        case (ctrl.line_sel)
            SPACE:      line_d = 1'b0;
            DATA_BIT:   line_d = data_q[0];
            PARITY_BIT: line_d = parity_q;
            default:    line_d = 1'b1;
        endcase
    end

    always_ff @(posedge s_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            uart_tx_o <= 1'b1;  // line idles at mark
        end else begin
            uart_tx_o <= line_d;
        end
    end

endmodule

`default_nettype wire

/* src/uart_pkg.sv */
// shared definitions for the uart transmitter
// frame state encoding, line source select, default widths
// and the parity function used by the shifter and the testbench
`default_nettype none

package uart_pkg;

    localparam int DEF_DATA_WIDTH    = 8;
    localparam int DEF_DIVIDER_WIDTH = 16;
    localparam int MAX_DATA_WIDTH    = 9;  // widest word the parity function accepts

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        START  = 3'd1,
        DATA   = 3'd2,
        PARITY = 3'd3,
        STOP   = 3'd4,
        WAIT   = 3'd5
    } uart_state_e;

    typedef enum logic [1:0] {
        MARK       = 2'd0,  // idle level and stop bit
        SPACE      = 2'd1,  // start bit
        DATA_BIT   = 2'd2,
        PARITY_BIT = 2'd3
    } line_sel_e;

    // zero extension of a narrow word leaves the xor unchanged
    function automatic logic parity_bit(
        input logic [MAX_DATA_WIDTH-1:0] word,
        input logic                      odd
    );
        logic even_par;
        even_par = ^word;
        return even_par ^ odd;
    endfunction

endpackage

`default_nettype wire

/* src/uart_tx_ctrl_if.sv */
// control link between the frame state machine and the shifter
// fsm and shifter modports
`default_nettype none

interface uart_tx_ctrl_if
    import uart_pkg::*;
#(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH
) ();

    logic      load;      // capture tdata and clear the bit count
    logic      shift;     // move on to the next data bit
    line_sel_e line_sel;  // source of the next line value
    logic      bit_last;  // current data bit is the final one

    // the frame format only makes sense for 5 to 9 data bits
    if (DATA_WIDTH < 5 || DATA_WIDTH > MAX_DATA_WIDTH) begin : g_width_check
        $error("DATA_WIDTH must lie between 5 and %0d", MAX_DATA_WIDTH);
    end

    modport fsm (
        output load,
        output shift,
        output line_sel,
        input  bit_last
    );

    modport shifter (
        input  load,
        input  shift,
        input  line_sel,
        output bit_last
    );

endinterface

`default_nettype wire

/* src/uart_tx_fsm.sv */
// frame state machine of the uart transmitter
// owns the stream handshake, enables the baud timer
// and steers load, shift and line source of the shifter
`default_nettype none

module uart_tx_fsm
    import uart_pkg::*;
(
    input  logic           s_axis,
    input  logic           rst_n_i,
    input  logic           s_axis_tvalid_i,
    output logic           s_axis_tready_o,
    input  logic           odd_i,
    input  logic           even_i,
    input  logic           baud_done_i,
    output logic           baud_en_o,
    uart_tx_ctrl_if.fsm    ctrl
);

    uart_state_e state_q;
    uart_state_e state_d;
    logic        parity_on;

    assign parity_on       = odd_i | even_i;
    assign s_axis_tready_o = (state_q == IDLE);
    assign ctrl.load       = s_axis_tvalid_i & s_axis_tready_o;

    // the timer runs from the handshake until the stop bit has elapsed
    assign baud_en_o = (state_q == START) || (state_q == DATA) ||
                       (state_q == PARITY) || (state_q == STOP);

    always_comb begin
        state_d       = state_q;
        ctrl.shift    = 1'b0;
        ctrl.line_sel = MARK;
        case (state_q)
            IDLE: begin
                if (s_axis_tvalid_i) begin
                    state_d = START;
                end
            end
            START: begin
                ctrl.line_sel = SPACE;
                if (baud_done_i) begin
                    state_d = DATA;
                end
            end
            DATA: begin
                ctrl.line_sel = DATA_BIT;
                if (baud_done_i) begin
                    if (ctrl.bit_last) begin
                        state_d = parity_on ? PARITY : STOP;
                    end else begin
                        ctrl.shift = 1'b1;
                    end
                end
            end
            PARITY: begin
                ctrl.line_sel = PARITY_BIT;
                if (baud_done_i) begin
                    state_d = STOP;
                end
            end
            STOP: begin
                if (baud_done_i) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                state_d = IDLE;  // one idle cycle before tready returns
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge s_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

/* src/uart_tx_top.sv */
// top level of the axi-stream uart transmitter
// ties the frame fsm, the baud timer and the shifter together
`default_nettype none

module uart_tx_top
    import uart_pkg::*;
#(
    parameter int DATA_WIDTH    = DEF_DATA_WIDTH,
    parameter int DIVIDER_WIDTH = DEF_DIVIDER_WIDTH
) (
    input  logic                     s_axis,
    input  logic                     rst_n_i,
    input  logic [DATA_WIDTH-1:0]    s_axis_tdata_i,
    input  logic                     s_axis_tvalid_i,
    output logic                     s_axis_tready_o,
    input  logic [DIVIDER_WIDTH-1:0] clk_divider_i,
    input  logic                     odd_i,
    input  logic                     even_i,
    output logic                     uart_tx_o
);

    logic baud_en;
    logic baud_done;

    uart_tx_ctrl_if #(.DATA_WIDTH(DATA_WIDTH)) ctrl_if ();

    baud_timer #(.DIVIDER_WIDTH(DIVIDER_WIDTH)) u_baud_timer (
        .s_axis        (s_axis),
        .rst_n_i       (rst_n_i),
        .baud_en_i     (baud_en),
        .clk_divider_i (clk_divider_i),
        .baud_done_o   (baud_done)
    );

    uart_tx_fsm u_fsm (
        .s_axis          (s_axis),
        .rst_n_i         (rst_n_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tready_o (s_axis_tready_o),
        .odd_i           (odd_i),
        .even_i          (even_i),
        .baud_done_i     (baud_done),
        .baud_en_o       (baud_en),
        .ctrl            (ctrl_if.fsm)
    );

    tx_shifter #(.DATA_WIDTH(DATA_WIDTH)) u_shifter (
        .s_axis         (s_axis),
        .rst_n_i        (rst_n_i),
        .s_axis_tdata_i (s_axis_tdata_i),
        .odd_i          (odd_i),
        .ctrl           (ctrl_if.shifter),
        .uart_tx_o      (uart_tx_o)
    );

endmodule

`default_nettype wire
